// ==== compile.f ====
+incdir+include
source/tag_store_pkg.sv
source/tag_way_ram.sv
source/victim_select.sv
source/tag_store_ctrl.sv
source/res_out_reg.sv
source/tag_store.sv
testbench/tag_store_chk.sv
testbench/tag_store_tb.sv

// ==== include/tag_store_config.svh ====
`ifndef TAG_STORE_CONFIG_SVH
`define TAG_STORE_CONFIG_SVH

// Associativity of the last-level cache
`define TS_NUM_WAYS 4

// Set index width
// 6 bits give 64 sets per way
`define TS_INDEX_W 6

// Width of the stored address tag
`define TS_TAG_W 10

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the tag store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
  --top-module tag_store_tb -o tag_store_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tag_store_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== source/res_out_reg.sv ====
`timescale 1ns/1ps

module res_out_reg
  import tag_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     in_hit_i,
  input  way_ind_t in_way_i,
  input  logic     in_evict_i,
  input  tag_t     in_evict_tag_i,
  output logic     res_valid_o,
  input  logic     res_ready_i,
  output logic     res_hit_o,
  output way_ind_t res_way_o,
  output logic     res_evict_o,
  output tag_t     res_evict_tag_o
);

  logic full_q;
  logic load;

  // Room when empty or when the held result leaves this cycle
  assign in_ready_o  = !full_q || res_ready_i;
  assign load        = in_valid_i && in_ready_o;
  assign res_valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (res_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload only changes on a load, so it is stable under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      res_hit_o       <= in_hit_i;
      res_way_o       <= in_way_i;
      res_evict_o     <= in_evict_i;
      res_evict_tag_o <= in_evict_tag_i;
    end
  end

endmodule

// ==== source/tag_store.sv ====
`timescale 1ns/1ps
`include "tag_store_config.svh"

module tag_store
  import tag_store_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  tag_mode_e req_mode_i,
  input  index_t    req_index_i,
  input  tag_t      req_tag_i,
  input  logic      req_dirty_i,
  input  way_ind_t  req_ways_i,
  input  way_ind_t  lock_i,
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output logic      res_hit_o,
  output way_ind_t  res_way_o,
  output logic      res_evict_o,
  output tag_t      res_evict_tag_o
);

  // RAM side
  way_ind_t                      ram_req;
  way_ind_t                      ram_we;
  index_t                        ram_index;
  tag_entry_t                    ram_wdata;
  tag_entry_t [`TS_NUM_WAYS-1:0] ram_rdata;
  // Victim choice
  way_ind_t                      lookup_ways;
  way_ind_t                      valid_vec;
  way_ind_t                      dirty_vec;
  way_ind_t                      victim;
  way_bin_t                      victim_bin;
  logic                          adv;
  // Result toward the output register
  logic                          out_valid;
  logic                          out_ready;
  logic                          out_hit;
  way_ind_t                      out_way;
  logic                          out_evict;
  tag_t                          out_evict_tag;

  // One tag RAM per way, index and write data are shared
  for (genvar i = 0; i < `TS_NUM_WAYS; i++) begin : gen_way
    tag_way_ram i_way_ram (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .ram_req_i   (ram_req[i]),
      .ram_we_i    (ram_we[i]),
      .ram_index_i (ram_index),
      .ram_wdata_i (ram_wdata),
      .ram_rdata_o (ram_rdata[i])
    );
  end

  tag_store_ctrl i_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_mode_i      (req_mode_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_ways_i      (req_ways_i),
    .ram_req_o       (ram_req),
    .ram_we_o        (ram_we),
    .ram_index_o     (ram_index),
    .ram_wdata_o     (ram_wdata),
    .ram_rdata_i     (ram_rdata),
    .ways_o          (lookup_ways),
    .victim_i        (victim),
    .victim_bin_i    (victim_bin),
    .adv_o           (adv),
    .valid_vec_o     (valid_vec),
    .dirty_vec_o     (dirty_vec),
    .out_valid_o     (out_valid),
    .out_ready_i     (out_ready),
    .out_hit_o       (out_hit),
    .out_way_o       (out_way),
    .out_evict_o     (out_evict),
    .out_evict_tag_o (out_evict_tag)
  );

  victim_select i_victim (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ways_i       (lookup_ways),
    .lock_i       (lock_i),
    .valid_i      (valid_vec),
    .dirty_i      (dirty_vec),
    .adv_i        (adv),
    .victim_o     (victim),
    .victim_bin_o (victim_bin)
  );

  res_out_reg i_out_reg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_valid_i      (out_valid),
    .in_ready_o      (out_ready),
    .in_hit_i        (out_hit),
    .in_way_i        (out_way),
    .in_evict_i      (out_evict),
    .in_evict_tag_i  (out_evict_tag),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

endmodule

// ==== source/tag_store_ctrl.sv ====
`timescale 1ns/1ps
`include "tag_store_config.svh"

module tag_store_ctrl
  import tag_store_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  tag_mode_e                     req_mode_i,
  input  index_t                        req_index_i,
  input  tag_t                          req_tag_i,
  input  logic                          req_dirty_i,
  input  way_ind_t                      req_ways_i,
  output way_ind_t                      ram_req_o,
  output way_ind_t                      ram_we_o,
  output index_t                        ram_index_o,
  output tag_entry_t                    ram_wdata_o,
  input  tag_entry_t [`TS_NUM_WAYS-1:0] ram_rdata_i,
  output way_ind_t                      ways_o,
  input  way_ind_t                      victim_i,
  input  way_bin_t                      victim_bin_i,
  output logic                          adv_o,
  output way_ind_t                      valid_vec_o,
  output way_ind_t                      dirty_vec_o,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          out_hit_o,
  output way_ind_t                      out_way_o,
  output logic                          out_evict_o,
  output tag_t                          out_evict_tag_o
);

  ctrl_state_e state_q;
  // Latched request
  tag_mode_e   mode_q;
  index_t      index_q;
  tag_t        tag_q;
  logic        dirty_q;
  way_ind_t    ways_q;

  way_ind_t    hit;
  logic        hit_any;
  logic        hit_dirty;
  logic        is_flush;
  tag_entry_t  flush_entry;
  tag_entry_t  sel_entry;
  logic        accept;
  logic        handoff;

  assign req_ready_o = (state_q == state_idle);
  assign accept      = req_ready_o && req_valid_i;
  assign out_valid_o = (state_q == state_resp);
  assign handoff     = out_valid_o && out_ready_i;
  assign is_flush    = (mode_q == mode_flush);
  assign ways_o      = ways_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= state_idle;
    end else begin
      case (state_q)
        state_idle: if (accept) state_q <= state_resp;
        state_resp: if (handoff) state_q <= state_idle;
        default:    state_q <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q  <= req_mode_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      ways_q  <= req_ways_i;
    end
  end

  // Per-way status and tag compare on the held read data
  for (genvar i = 0; i < `TS_NUM_WAYS; i++) begin : gen_cmp
    assign valid_vec_o[i] = entry_valid(ram_rdata_i[i]);
    assign dirty_vec_o[i] = entry_dirty(ram_rdata_i[i]);
    assign hit[i] = ways_q[i] && valid_vec_o[i] && (entry_tag(ram_rdata_i[i]) == tag_q);
  end

  assign hit_any   = |hit;
  assign hit_dirty = |(hit & dirty_vec_o);

  // Flush names a single way, so an OR over the mask selects it
  always_comb begin
    flush_entry = '0;
    for (int i = 0; i < `TS_NUM_WAYS; i++) begin
      if (ways_q[i]) begin
        flush_entry = flush_entry | ram_rdata_i[i];
      end
    end
  end

  // Entry that leaves the cache, flush way or miss victim
  assign sel_entry = is_flush ? flush_entry : ram_rdata_i[victim_bin_i];

  assign out_hit_o       = !is_flush && hit_any;
  assign out_way_o       = is_flush ? ways_q : (hit_any ? hit : victim_i);
  assign out_evict_o     = !out_hit_o && entry_valid(sel_entry) && entry_dirty(sel_entry);
  assign out_evict_tag_o = out_evict_o ? entry_tag(sel_entry) : '0;

  // Round-robin moves only when a miss result is handed off
  assign adv_o = handoff && !is_flush && !hit_any;

  always_comb begin
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = index_q;
    ram_wdata_o = '0;
    if (state_q == state_idle) begin
      // Read straight from the request so data is ready in Resp
      ram_index_o = req_index_i;
      if (req_valid_i) begin
        ram_req_o = req_ways_i;
      end
    end else if (handoff) begin
      if (is_flush) begin
        ram_req_o = ways_q;
        ram_we_o  = ways_q;
      end else if (!hit_any) begin
        // Refill the victim with the new tag
        ram_req_o   = victim_i;
        ram_we_o    = victim_i;
        ram_wdata_o = make_entry(1'b1, dirty_q, tag_q);
      end else if (dirty_q && !hit_dirty) begin
        // Clean hit turned dirty
        ram_req_o   = hit;
        ram_we_o    = hit;
        ram_wdata_o = make_entry(1'b1, 1'b1, tag_q);
      end
    end
  end

endmodule

// ==== source/tag_store_pkg.sv ====
`include "tag_store_config.svh"

package tag_store_pkg;

  // One bit per way, used for enables, locks and hit vectors
  typedef logic [`TS_NUM_WAYS-1:0] way_ind_t;
  // Set index, doubles as the tag RAM address
  typedef logic [`TS_INDEX_W-1:0]  index_t;
  typedef logic [`TS_TAG_W-1:0]    tag_t;
  // Binary way number
  typedef logic [1:0]              way_bin_t;
  // Stored entry: valid on top, dirty below it, tag in the low bits
  typedef logic [`TS_TAG_W+1:0]    tag_entry_t;

  typedef enum logic {
    mode_lookup = 1'b0,
    mode_flush  = 1'b1
  } tag_mode_e;

  typedef enum logic {
    state_idle = 1'b0,
    state_resp = 1'b1
  } ctrl_state_e;

  // Field access on a stored entry
  function automatic logic entry_valid(input tag_entry_t entry);
    return entry[`TS_TAG_W+1];
  endfunction

  function automatic logic entry_dirty(input tag_entry_t entry);
    return entry[`TS_TAG_W];
  endfunction

  function automatic tag_t entry_tag(input tag_entry_t entry);
    return entry[`TS_TAG_W-1:0];
  endfunction

  function automatic tag_entry_t make_entry(input logic valid, input logic dirty,
                                            input tag_t tag);
    return {valid, dirty, tag};
  endfunction

endpackage

// ==== source/tag_way_ram.sv ====
`timescale 1ns/1ps
`include "tag_store_config.svh"

module tag_way_ram
  import tag_store_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       ram_req_i,
  input  logic       ram_we_i,
  input  index_t     ram_index_i,
  input  tag_entry_t ram_wdata_i,
  output tag_entry_t ram_rdata_o
);

  localparam int NUM_SETS = 1 << `TS_INDEX_W;

  // Dirty bit and tag per set
  logic [`TS_TAG_W:0]  body_mem [NUM_SETS];
  // Valid bits live apart so reset can clear them
  logic [NUM_SETS-1:0] valid_q;

  always_ff @(posedge clk_i) begin
    if (ram_req_i && ram_we_i) begin
      body_mem[ram_index_i] <= {entry_dirty(ram_wdata_i), entry_tag(ram_wdata_i)};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (ram_req_i && ram_we_i) begin
      valid_q[ram_index_i] <= entry_valid(ram_wdata_i);
    end
  end

  // Read data is registered and held until the next read
  // An invalid set reads back as all zero
  always_ff @(posedge clk_i) begin
    if (ram_req_i && !ram_we_i) begin
      if (valid_q[ram_index_i]) begin
        ram_rdata_o <= make_entry(1'b1, body_mem[ram_index_i][`TS_TAG_W],
                                  body_mem[ram_index_i][`TS_TAG_W-1:0]);
      end else begin
        ram_rdata_o <= '0;
      end
    end
  end

endmodule

// ==== source/victim_select.sv ====
`timescale 1ns/1ps
`include "tag_store_config.svh"

module victim_select
  import tag_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  way_ind_t ways_i,
  input  way_ind_t lock_i,
  input  way_ind_t valid_i,
  input  way_ind_t dirty_i,
  input  logic     adv_i,
  output way_ind_t victim_o,
  output way_bin_t victim_bin_o
);

  way_ind_t cand;
  way_ind_t free;
  way_bin_t ptr_q;
  way_bin_t scan;
  logic     found;

  // Only enabled and unlocked ways may be replaced
  assign cand = ways_i & ~lock_i;
  // Invalid entries read back all zero, so a free way has neither bit set
  assign free = cand & ~valid_i & ~dirty_i;

  always_comb begin
    victim_bin_o = '0;
    found        = 1'b0;
    scan         = '0;
    if (|free) begin
      // Lowest free way wins, so scan downward and keep the last match
      for (int i = `TS_NUM_WAYS - 1; i >= 0; i--) begin
        if (free[i]) begin
          victim_bin_o = way_bin_t'(i);
        end
      end
    end else begin
      // All candidates valid
      // take the first one at or after the pointer, wrapping
      for (int i = 0; i < `TS_NUM_WAYS; i++) begin
        scan = ptr_q + way_bin_t'(i);
        if (!found && cand[scan]) begin
          victim_bin_o = scan;
          found        = 1'b1;
        end
      end
    end
  end

  // No candidate at all gives an empty victim
  assign victim_o = (|cand) ? (way_ind_t'(1) << victim_bin_o) : '0;

  // Pointer moves past the victim only when it was used for the choice
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (adv_i && !(|free)) begin
      ptr_q <= victim_bin_o + way_bin_t'(1);
    end
  end

endmodule

// ==== testbench/tag_store_chk.sv ====
`timescale 1ns/1ps

module tag_store_chk
  import tag_store_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     req_ready_o,
  input logic     res_valid_o,
  input logic     res_ready_i,
  input logic     res_hit_o,
  input way_ind_t res_way_o,
  input logic     res_evict_o,
  input tag_t     res_evict_tag_o
);

  // A valid response names exactly one way
  a_way_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    res_valid_o |-> $onehot(res_way_o))
    else $error("Response way is not one-hot");

  // Stalled response keeps every output
  a_res_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_hit_o) &&
    $stable(res_way_o) && $stable(res_evict_o) && $stable(res_evict_tag_o)))
    else $error("Response changed under back-pressure");

  // Controller holding a result cannot take a new request
  a_ready_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_valid_o && !res_ready_i && !req_ready_o) |=> !req_ready_o)
    else $error("Request ready rose while a response was stalled");

endmodule

bind tag_store tag_store_chk i_chk (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .req_ready_o     (req_ready_o),
  .res_valid_o     (res_valid_o),
  .res_ready_i     (res_ready_i),
  .res_hit_o       (res_hit_o),
  .res_way_o       (res_way_o),
  .res_evict_o     (res_evict_o),
  .res_evict_tag_o (res_evict_tag_o)
);

// ==== testbench/tag_store_tb.sv ====
`timescale 1ns/1ps
`include "tag_store_config.svh"

module tag_store_tb
  import tag_store_pkg::*;
();

  localparam int TIMEOUT  = 50;
  localparam int NUM_SETS = 1 << `TS_INDEX_W;

  logic      clk;
  logic      reset;
  logic      req_valid;
  logic      req_ready;
  tag_mode_e req_mode;
  index_t    req_index;
  tag_t      req_tag;
  logic      req_dirty;
  way_ind_t  req_ways;
  way_ind_t  lock_r;
  logic      res_valid;
  logic      res_ready;
  logic      res_hit;
  way_ind_t  res_way;
  logic      res_evict;
  tag_t      res_evict_tag;

  // Reference model of the tag arrays and round-robin pointer
  logic      m_valid [`TS_NUM_WAYS][NUM_SETS];
  logic      m_dirty [`TS_NUM_WAYS][NUM_SETS];
  tag_t      m_tag   [`TS_NUM_WAYS][NUM_SETS];
  way_bin_t  m_ptr;
  // Expected responses in request order
  logic      exp_hit_q [$];
  way_ind_t  exp_way_q [$];
  logic      exp_evict_q [$];
  tag_t      exp_tag_q [$];
  // Last response seen
  logic      last_hit;
  way_ind_t  last_way;
  logic      last_evict;
  tag_t      last_tag;

  logic [15:0] lfsr;
  int          errors;
  logic        timed_out;
  string       test_name;

  tag_store UUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_mode_i      (req_mode),
    .req_index_i     (req_index),
    .req_tag_i       (req_tag),
    .req_dirty_i     (req_dirty),
    .req_ways_i      (req_ways),
    .lock_i          (lock_r),
    .res_valid_o     (res_valid),
    .res_ready_i     (res_ready),
    .res_hit_o       (res_hit),
    .res_way_o       (res_way),
    .res_evict_o     (res_evict),
    .res_evict_tag_o (res_evict_tag)
  );

  always #5 clk = ~clk;

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (!timed_out && exp !== act) begin
      errors++;
      $display("[ERROR] %s %s: expected %0b, got %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_way(input string what, input way_ind_t exp, input way_ind_t act);
    if (!timed_out && exp !== act) begin
      errors++;
      $display("[ERROR] %s %s: expected %b, got %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_tag(input string what, input tag_t exp, input tag_t act);
    if (!timed_out && exp !== act) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, got %h", test_name, what, exp, act);
    end
  endtask

  // Applies lookup and flush rules, updates the model, returns the expected result
  task automatic model_request(input tag_mode_e mode, input index_t idx, input tag_t tag,
                               input logic dirty, input way_ind_t ways, output logic hit,
                               output way_ind_t way, output logic evict, output tag_t etag);
    int v;
    int j;
    hit   = 1'b0;
    way   = '0;
    evict = 1'b0;
    etag  = '0;
    v     = -1;
    for (int i = 0; i < `TS_NUM_WAYS; i++) begin
      if (mode == mode_flush && ways[i]) v = i;
      if (mode == mode_lookup && ways[i] && m_valid[i][idx] && m_tag[i][idx] == tag) begin
        hit = 1'b1;
        v   = i;
      end
    end
    if (hit) begin
      // Clean entry turns dirty on a dirty hit
      way[v]          = 1'b1;
      m_dirty[v][idx] = m_dirty[v][idx] | dirty;
      return;
    end
    if (mode == mode_lookup) begin
      // Lowest free candidate first
      for (int i = 0; i < `TS_NUM_WAYS; i++) begin
        if (v < 0 && ways[i] && !lock_r[i] && !m_valid[i][idx]) v = i;
      end
      // Otherwise round-robin from the pointer
      if (v < 0) begin
        for (int k = 0; k < `TS_NUM_WAYS; k++) begin
          j = (int'(m_ptr) + k) % `TS_NUM_WAYS;
          if (v < 0 && ways[j] && !lock_r[j]) v = j;
        end
        m_ptr = way_bin_t'((v + 1) % `TS_NUM_WAYS);
      end
    end
    way[v] = 1'b1;
    evict  = m_valid[v][idx] && m_dirty[v][idx];
    etag   = evict ? m_tag[v][idx] : '0;
    m_valid[v][idx] = (mode == mode_lookup);
    m_dirty[v][idx] = (mode == mode_lookup) && dirty;
    m_tag[v][idx]   = (mode == mode_lookup) ? tag : '0;
  endtask

  task automatic send_req(input tag_mode_e mode, input index_t idx, input tag_t tag,
                          input logic dirty, input way_ind_t ways);
    logic     hit;
    way_ind_t way;
    logic     evict;
    tag_t     etag;
    int       n;
    if (timed_out) return;
    req_valid = 1'b1;
    req_mode  = mode;
    req_index = idx;
    req_tag   = tag;
    req_dirty = dirty;
    req_ways  = ways;
    n = 0;
    while (!req_ready && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!req_ready) begin
      timed_out = 1'b1;
      req_valid = 1'b0;
      $display("Timeout: request was never accepted in test %s", test_name);
      return;
    end
    // Acceptance edge
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    model_request(mode, idx, tag, dirty, ways, hit, way, evict, etag);
    exp_hit_q.push_back(hit);
    exp_way_q.push_back(way);
    exp_evict_q.push_back(evict);
    exp_tag_q.push_back(etag);
  endtask

  // Waits for a response, compares it, then lets it transfer
  task automatic recv_resp();
    int n;
    if (timed_out) return;
    n = 0;
    while (!res_valid && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!res_valid) begin
      timed_out = 1'b1;
      $display("Timeout: no response arrived in test %s", test_name);
      return;
    end
    if (exp_hit_q.size() == 0) begin
      errors++;
      $display("A response arrived with no request pending in test %s", test_name);
    end else begin
      check_bit("hit", exp_hit_q.pop_front(), res_hit);
      check_way("way", exp_way_q.pop_front(), res_way);
      check_bit("evict", exp_evict_q.pop_front(), res_evict);
      check_tag("evict tag", exp_tag_q.pop_front(), res_evict_tag);
    end
    last_hit   = res_hit;
    last_way   = res_way;
    last_evict = res_evict;
    last_tag   = res_evict_tag;
    @(posedge clk);
    #1;
  endtask

  task automatic do_request(input tag_mode_e mode, input index_t idx, input tag_t tag,
                            input logic dirty, input way_ind_t ways);
    send_req(mode, idx, tag, dirty, ways);
    recv_resp();
  endtask

  task automatic test_reset_miss();
    test_name = "reset_miss";
    check_bit("ready after reset", 1'b1, req_ready);
    check_bit("valid after reset", 1'b0, res_valid);
    for (int s = 0; s < 4; s++) begin
      do_request(mode_lookup, index_t'(s), tag_t'(10'h040 + s), 1'b0, 4'b1111);
      check_bit("first lookup hit", 1'b0, last_hit);
      check_bit("first lookup evict", 1'b0, last_evict);
      check_way("first victim", 4'b0001, last_way);
    end
  endtask

  task automatic test_fill_hit();
    logic [15:0] r;
    index_t      idx;
    tag_t        tag;
    way_ind_t    w;
    test_name = "fill_hit";
    repeat (8) begin
      rand_bits(`TS_INDEX_W, r);
      idx = index_t'(r);
      rand_bits(`TS_TAG_W, r);
      tag = tag_t'(r);
      do_request(mode_lookup, idx, tag, 1'b0, 4'b1111);
      w = last_way;
      do_request(mode_lookup, idx, tag, 1'b0, 4'b1111);
      check_bit("second lookup hit", 1'b1, last_hit);
      check_way("hit way", w, last_way);
    end
  endtask

  task automatic test_dirty_flush();
    way_ind_t w;
    test_name = "dirty_flush";
    do_request(mode_lookup, 6'd40, 10'h2a5, 1'b0, 4'b1111);
    do_request(mode_lookup, 6'd40, 10'h2a5, 1'b1, 4'b1111);
    w = last_way;
    do_request(mode_flush, 6'd40, '0, 1'b0, w);
    check_bit("flush of dirty way", 1'b1, last_evict);
    check_tag("flushed tag", 10'h2a5, last_tag);
    do_request(mode_flush, 6'd40, '0, 1'b0, w);
    check_bit("second flush", 1'b0, last_evict);
    do_request(mode_lookup, 6'd40, 10'h2a5, 1'b0, 4'b1111);
    check_bit("lookup after flush", 1'b0, last_hit);
  endtask

  task automatic test_full_set();
    test_name = "full_set";
    // Empty the set, then fill it with odd ways dirty
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      do_request(mode_flush, 6'd50, '0, 1'b0, way_ind_t'(1) << w);
    end
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      do_request(mode_lookup, 6'd50, tag_t'(10'h300 + w), w[0], 4'b1111);
    end
    for (int k = 0; k < 6; k++) begin
      // Way 1 locked for the later misses
      lock_r = (k >= 3) ? 4'b0010 : 4'b0000;
      do_request(mode_lookup, 6'd50, tag_t'(10'h310 + k), k[0], 4'b1111);
      check_bit("miss in full set", 1'b0, last_hit);
    end
    lock_r = '0;
  endtask

  task automatic test_back_pressure();
    int edges;
    test_name = "back_pressure";
    res_ready = 1'b0;
    send_req(mode_lookup, 6'd12, 10'h0c1, 1'b1, 4'b1111);
    send_req(mode_lookup, 6'd13, 10'h0d2, 1'b0, 4'b1111);
    repeat (5) begin
      @(posedge clk);
      #1;
      check_bit("ready under back-pressure", 1'b0, req_ready);
      check_bit("valid under back-pressure", 1'b1, res_valid);
    end
    res_ready = 1'b1;
    recv_resp();
    recv_resp();
    // Counting the acceptance edge, valid comes on the second edge
    send_req(mode_lookup, 6'd12, 10'h0c1, 1'b0, 4'b1111);
    edges = 1;
    while (!res_valid && edges < TIMEOUT) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (!timed_out && edges != 2) begin
      errors++;
      $display("[ERROR] %s latency: expected 2, got %0d", test_name, edges);
    end
    recv_resp();
  endtask

  task automatic test_enable_mask();
    way_ind_t w;
    test_name = "enable_mask";
    do_request(mode_lookup, 6'd60, 10'h155, 1'b0, 4'b1111);
    w = last_way;
    do_request(mode_lookup, 6'd60, 10'h155, 1'b0, ~w);
    check_bit("lookup with hit way disabled", 1'b0, last_hit);
    check_way("refill outside disabled way", 4'b0000, last_way & w);
    // Drop the first copy so the set holds the tag once
    do_request(mode_flush, 6'd60, '0, 1'b0, w);
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_mode  = mode_lookup;
    req_index = '0;
    req_tag   = '0;
    req_dirty = 1'b0;
    req_ways  = '0;
    lock_r    = '0;
    res_ready = 1'b1;
    errors    = 0;
    timed_out = 1'b0;
    lfsr      = 16'd28;
    m_ptr     = '0;
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_miss();
    test_fill_hit();
    test_dirty_flush();
    test_full_set();
    test_back_pressure();
    test_enable_mask();
    $display("Summary: %0d errors, %0d timeouts", errors, timed_out ? 1 : 0);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
